/* vlog.f */
+incdir+hdl
hdl/agen_pkg.sv
hdl/register_view.sv
hdl/operand_select.sv
hdl/stage_register.sv
hdl/agen_top.sv
bench/agen_tb.sv

/* Makefile */
# Verilator flow for the address generation stage
TOP = agen_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f vlog.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/agen_tb.sv */
/*
 * Testbench for the address generation stage. Random requests and register
 * snapshots go in, a reference model queues the expected responses, and
 * concurrent assertions compare them at the output. Run through vlog.f.
 */

`timescale 1ns/1ps

`include "agen_config.svh"

module agen_tb
    import agen_pkg::*;
();

    localparam int NUM_REQS = 408;
    localparam int CYCLE_LIMIT = 4 * NUM_REQS + 100;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        flush;
    logic        req_valid;
    logic        req_ready;
    agen_req_t   req;
    arch_state_t state;
    logic        rsp_valid;
    logic        rsp_ready;
    agen_resp_t  rsp;

    agen_resp_t exp_q[$];
    int         tid_q[$];
    agen_resp_t exp_head;
    int         exp_tid;
    logic       exp_avail = 1'b0;
    logic       accepted = 1'b0;
    int         cur_tid = 0;
    int         cycles = 0;
    int         checked = 0;
    int         value_errors = 0;
    int         protocol_errors = 0;
    logic [46:0] got_side;
    logic [46:0] exp_side;

    agen_top i_agen_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .state     (state),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    always #50 clk = ~clk;

    function automatic string test_name(input int tid);
        case (tid)
            0: return "reg_views";
            1: return "src_kinds";
            2: return "string_mem";
            3: return "stack_pop";
            4: return "handshake";
            default: return "flush";
        endcase
    endfunction

    // reference model of the register views and operand kinds
    function automatic logic [63:0] sized_reg(arch_state_t s, opnd_size_e size,
                                              logic [2:0] idx);
        logic [63:0] v;
        v = '0;
        case (size)
            SZ_8: v[7:0] = idx[2] ? s.gpr[idx[1:0]][15:8] : s.gpr[idx[1:0]][7:0];
            SZ_16: v[15:0] = s.gpr[idx][15:0];
            SZ_32: v[31:0] = s.gpr[idx];
            SZ_MMX: v = s.mmx[idx];
            default: v = '0;
        endcase
        return v;
    endfunction

    function automatic logic [15:0] seg_value(arch_state_t s, logic [2:0] idx);
        return (idx < 3'd6) ? s.seg[idx] : 16'h0;
    endfunction

    // segment times 16 plus offset
    function automatic logic [31:0] str_addr(logic [15:0] seg, logic [31:0] off);
        return 32'({seg, 4'h0}) + off;
    endfunction

    function automatic logic [63:0] slot_value(arch_state_t s, agen_req_t r,
                                               opnd_kind_e kind, logic [2:0] idx,
                                               logic [31:0] addr);
        logic [63:0] v;
        v = '0;
        case (kind)
            REGISTER: v = sized_reg(s, r.size, idx);
            SEGMENT: v[15:0] = seg_value(s, idx);
            MMX: v = s.mmx[idx];
            IMMEDIATE: v[47:0] = r.imm;
            MEMORY: v[31:0] = addr;
            default: v = '0;
        endcase
        return v;
    endfunction

    function automatic agen_resp_t model(agen_req_t r, arch_state_t s);
        agen_resp_t e;
        logic [15:0] src_seg;
        logic [31:0] addr0;
        logic [31:0] addr1;
        src_seg = r.seg_override_valid ? seg_value(s, r.seg_override) : s.seg[DS];
        addr0 = str_addr(s.seg[ES], s.gpr[7]);
        addr1 = str_addr(src_seg, s.gpr[6]);
        e.size = r.size;
        e.op0 = slot_value(s, r, r.op0_kind, r.op0_reg, addr0);
        e.op1 = r.stack_op[1] ? {32'h0, r.stack_address}
                              : slot_value(s, r, r.op1_kind, r.op1_reg, addr1);
        e.op0_reg = r.op0_reg;
        e.op1_reg = r.op1_reg;
        e.op0_is_reg = (r.op0_kind == REGISTER);
        e.op0_is_segment = (r.op0_kind == SEGMENT);
        e.op0_is_mmx = (r.size == SZ_MMX);
        e.op1_is_address = (r.op1_kind == MEMORY) || r.stack_op[1];
        e.stack_op = r.stack_op;
        e.stack_address = r.stack_address;
        return e;
    endfunction

    function automatic arch_state_t rand_state();
        arch_state_t s;
        for (int i = 0; i < `AGEN_NUM_REGS; i++) begin
            s.gpr[i] = $urandom();
            s.mmx[i] = {$urandom(), $urandom()};
        end
        for (int i = 0; i < AGEN_NUM_SEGS; i++) begin
            s.seg[i] = 16'($urandom());
        end
        return s;
    endfunction

    function automatic agen_req_t rand_req();
        agen_req_t r;
        r.size = opnd_size_e'(3'($urandom()));
        r.op0_kind = opnd_kind_e'(3'($urandom()));
        r.op1_kind = opnd_kind_e'(3'($urandom()));
        r.op0_reg = 3'($urandom());
        r.op1_reg = 3'($urandom());
        r.imm = {16'($urandom()), $urandom()};
        r.stack_op = stack_op_e'(2'($urandom()));
        r.stack_address = $urandom();
        r.seg_override = seg_idx_e'(3'($urandom()));
        r.seg_override_valid = 1'($urandom());
        return r;
    endfunction

    // holds the request until the stage takes it
    task automatic send_req(input agen_req_t r, input int tid, input int stall_pct);
        req = r;
        state = rand_state();
        cur_tid = tid;
        req_valid = 1'b1;
        do begin
            rsp_ready = int'($urandom_range(99)) >= stall_pct;
            @(negedge clk);
        end while (!accepted);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        req_valid = 1'b0;
        while (exp_q.size() != 0) begin
            rsp_ready = $urandom_range(1) == 1;
            @(negedge clk);
        end
        rsp_ready = 1'b1;
    endtask

    // flush a stalled item while a new request rides along
    task automatic flush_held();
        req = rand_req();
        state = rand_state();
        req_valid = 1'b1;
        rsp_ready = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        req_valid = 1'b0;
        rsp_ready = 1'b1;
        @(negedge clk);
    endtask

    // scoreboard runs on the values from before the edge
    always @(posedge clk) begin
        cycles++;
        accepted = 1'b0;
        if (!rst_n) begin
            exp_q.delete();
            tid_q.delete();
        end else begin
            if (rsp_valid && rsp_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                void'(tid_q.pop_front());
                checked++;
            end
            if (flush) begin
                exp_q.delete();
                tid_q.delete();
            end else if (req_valid && req_ready) begin
                exp_q.push_back(model(req, state));
                tid_q.push_back(cur_tid);
                accepted = 1'b1;
            end
        end
        exp_avail = exp_q.size() > 0;
        if (exp_avail) begin
            exp_head = exp_q[0];
            exp_tid = tid_q[0];
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d responses outstanding", cycles, exp_q.size());
            $display("Some tests failed");
            $finish;
        end
    end

    assign got_side = {rsp.size, rsp.op0_reg, rsp.op1_reg, rsp.op0_is_reg, rsp.op0_is_segment,
                       rsp.op0_is_mmx, rsp.op1_is_address, rsp.stack_op, rsp.stack_address};
    assign exp_side = {exp_head.size, exp_head.op0_reg, exp_head.op1_reg, exp_head.op0_is_reg,
                       exp_head.op0_is_segment, exp_head.op0_is_mmx, exp_head.op1_is_address,
                       exp_head.stack_op, exp_head.stack_address};

    a_op0: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && exp_avail |-> rsp.op0 == exp_head.op0)
        else begin
            value_errors++;
            $display("** Error [%s] op0: expected %h, actual %h", test_name($sampled(exp_tid)),
                     $sampled(exp_head.op0), $sampled(rsp.op0));
        end

    a_op1: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && exp_avail |-> rsp.op1 == exp_head.op1)
        else begin
            value_errors++;
            $display("** Error [%s] op1: expected %h, actual %h", test_name($sampled(exp_tid)),
                     $sampled(exp_head.op1), $sampled(rsp.op1));
        end

    // size, register indices, flags and stack fields
    a_side: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && exp_avail |-> got_side == exp_side)
        else begin
            value_errors++;
            $display("** Error [%s] flags: expected %h, actual %h", test_name($sampled(exp_tid)),
                     $sampled(exp_side), $sampled(got_side));
        end

    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> exp_avail)
        else begin
            protocol_errors++;
            $display("response seen with no accepted request waiting for it");
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && req_ready && !flush |=> rsp_valid)
        else begin
            protocol_errors++;
            $display("no response one cycle after the request was accepted");
        end

    // ready when empty or when the memory stage takes the held item
    a_ready: assert property (@(posedge clk) disable iff (!rst_n)
        req_ready == (rsp_ready || !rsp_valid))
        else begin
            protocol_errors++;
            $display("req_ready does not follow the held item and rsp_ready");
        end

    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready && !flush |=> rsp_valid && $stable(rsp))
        else begin
            protocol_errors++;
            $display("held response changed or dropped while stalled");
        end

    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !rsp_valid)
        else begin
            protocol_errors++;
            $display("rsp_valid still high the cycle after a flush");
        end

    a_reset: assert property (@(posedge clk) !rst_n |=> !rsp_valid)
        else begin
            protocol_errors++;
            $display("rsp_valid high right after reset");
        end

    initial begin
        agen_req_t r;
        void'($urandom(32'hba2b_268c));
        rst_n = 1'b0;
        flush = 1'b0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        req = '0;
        state = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // every size code against every register index
        for (int sz = 0; sz < 8; sz++) begin
            for (int idx = 0; idx < 8; idx++) begin
                r = rand_req();
                r.size = opnd_size_e'(3'(sz));
                r.op0_kind = REGISTER;
                r.op1_kind = REGISTER;
                r.op0_reg = 3'(idx);
                r.op1_reg = 3'(7 - idx);
                r.stack_op = ST_NONE;
                send_req(r, 0, 0);
            end
        end

        for (int i = 0; i < 64; i++) begin
            r = rand_req();
            r.op0_kind = opnd_kind_e'(3'(i / 8));
            r.op1_kind = opnd_kind_e'(3'(7 - i / 8));
            r.stack_op = i[0] ? ST_PUSH : ST_NONE;
            send_req(r, 1, 20);
        end

        for (int i = 0; i < 32; i++) begin
            r = rand_req();
            r.op0_kind = MEMORY;
            r.op1_kind = MEMORY;
            r.stack_op = ST_NONE;
            send_req(r, 2, 20);
        end

        // pops override op1 whatever its kind
        for (int i = 0; i < 32; i++) begin
            r = rand_req();
            r.stack_op = i[0] ? ST_POP : ST_POP2;
            send_req(r, 3, 20);
        end

        for (int i = 0; i < 200; i++) begin
            send_req(rand_req(), 4, 50);
        end

        for (int i = 0; i < 8; i++) begin
            drain();
            send_req(rand_req(), 5, 0);
            flush_held();
        end

        drain();
        repeat (3) @(negedge clk);
        assert (exp_q.size() == 0)
            else begin
                protocol_errors++;
                $display("%0d accepted requests never produced a response", exp_q.size());
            end
        $display("responses checked %0d, value errors %0d, protocol errors %0d",
                 checked, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* hdl/agen_top.sv */
/*
 * Address generation stage top. Register view feeds one operand selector
 * per slot, and the stage register drains them toward the memory stage.
 */

`timescale 1ns/1ps

`include "agen_config.svh"

module agen_top
    import agen_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,

    input  logic        req_valid,
    output logic        req_ready,
    input  agen_req_t   req,
    input  arch_state_t state,

    output logic        rsp_valid,
    input  logic        rsp_ready,
    output agen_resp_t  rsp
);

    opnd_bank_t bank;
    logic [`AGEN_NUM_OPND-1:0][`AGEN_GPR_W-1:0] string_addr;
    logic [`AGEN_NUM_OPND-1:0][`AGEN_OPND_W-1:0] op_values;
    opnd_req_t [`AGEN_NUM_OPND-1:0] slot_sel;

    register_view i_register_view (
        .state              (state),
        .size               (req.size),
        .seg_override       (req.seg_override),
        .seg_override_valid (req.seg_override_valid),
        .bank               (bank),
        .string_addr        (string_addr)
    );

    // per-slot selector inputs
    assign slot_sel[0] = '{kind: req.op0_kind, reg_idx: req.op0_reg,
                           imm: req.imm, str_addr: string_addr[0]};
    assign slot_sel[1] = '{kind: req.op1_kind, reg_idx: req.op1_reg,
                           imm: req.imm, str_addr: string_addr[1]};

    for (genvar i = 0; i < `AGEN_NUM_OPND; i++) begin : g_opnd
        operand_select i_operand_select (
            .sel   (slot_sel[i]),
            .bank  (bank),
            .segs  (state.seg),
            .mmx   (state.mmx),
            .value (op_values[i])
        );
    end

    stage_register i_stage_register (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .op_values (op_values),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

endmodule

/* hdl/stage_register.sv */
/*
 * Output pipe stage of address generation. Builds the operand flags, forces
 * op1 to the stack address on pops and holds one response behind valid/ready.
 */

`timescale 1ns/1ps

`include "agen_config.svh"

module stage_register
    import agen_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,

    input  logic       req_valid,
    output logic       req_ready,
    input  agen_req_t  req,
    input  logic [`AGEN_NUM_OPND-1:0][`AGEN_OPND_W-1:0] op_values,

    output logic       rsp_valid,
    input  logic       rsp_ready,
    output agen_resp_t rsp
);

    agen_resp_t next_rsp;
    logic is_pop;
    logic accept;
    logic [`AGEN_OPND_W-1:0] stack_ext;

    assign is_pop = req.stack_op[1];

    always_comb begin
        stack_ext = '0;
        stack_ext[`AGEN_GPR_W-1:0] = req.stack_address;
    end

    always_comb begin
        next_rsp.size = req.size;
        next_rsp.op0 = op_values[0];
        // pops read from the stack top whatever op1 names
        next_rsp.op1 = is_pop ? stack_ext : op_values[1];
        next_rsp.op0_reg = req.op0_reg;
        next_rsp.op1_reg = req.op1_reg;
        next_rsp.op0_is_reg = (req.op0_kind == REGISTER);
        next_rsp.op0_is_segment = (req.op0_kind == SEGMENT);
        next_rsp.op0_is_mmx = (req.size == SZ_MMX);
        next_rsp.op1_is_address = (req.op1_kind == MEMORY) || is_pop;
        next_rsp.stack_op = req.stack_op;
        next_rsp.stack_address = req.stack_address;
    end

    // free slot, or the held item leaves this cycle
    assign req_ready = !rsp_valid || rsp_ready;
    assign accept = req_valid && req_ready && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (flush) begin
            rsp_valid <= 1'b0;
        end else if (req_ready) begin
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp <= next_rsp;
        end
    end

    // held response must not move under back-pressure
    a_rsp_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> $stable(rsp)
    ) else $error("rsp changed while stalled");

    // a flushed entry never shows up the next cycle
    a_flush_clears: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !rsp_valid
    ) else $error("rsp_valid high after flush");

endmodule

/* hdl/operand_select.sv */
/*
 * One operand slot: picks a 64-bit value from the sized bank, a segment,
 * an MMX register, the immediate or the string address, by operand kind.
 */

`timescale 1ns/1ps

`include "agen_config.svh"

module operand_select
    import agen_pkg::*;
(
    input  opnd_req_t  sel,
    input  opnd_bank_t bank,
    input  seg_bank_t  segs,
    input  opnd_bank_t mmx,
    output logic [`AGEN_OPND_W-1:0] value
);

    always_comb begin
        value = '0;
        case (sel.kind)
            REGISTER: begin
                value = bank[sel.reg_idx];
            end
            SEGMENT: begin
                value[`AGEN_SEG_W-1:0] = seg_read(segs, seg_idx_e'(sel.reg_idx));
            end
            MMX: begin
                value = mmx[sel.reg_idx];
            end
            IMMEDIATE: begin
                value[`AGEN_IMM_W-1:0] = sel.imm;
            end
            MEMORY: begin
                value[`AGEN_GPR_W-1:0] = sel.str_addr;
            end
            // mod r/m is no longer computed here, reads as zero like none
            default: begin
                value = '0;
            end
        endcase
    end

    // clean inputs must never produce an X operand
    always_comb begin
        if (!$isunknown({sel, bank, segs, mmx})) begin
            assert final (!$isunknown(value))
                else $error("operand value unknown for kind %0d", sel.kind);
        end
    end

endmodule

/* hdl/register_view.sv */
/*
 * Size-selected view of the general and MMX registers, plus the two
 * string linear addresses (ES:EDI and DS:ESI or override). Purely combinational.
 */

`timescale 1ns/1ps

`include "agen_config.svh"

module register_view
    import agen_pkg::*;
(
    input  arch_state_t state,
    input  opnd_size_e  size,
    input  seg_idx_e    seg_override,
    input  logic        seg_override_valid,
    output opnd_bank_t  bank,
    output logic [`AGEN_NUM_OPND-1:0][`AGEN_GPR_W-1:0] string_addr
);

    // x86 register numbering
    localparam int ESI_IDX = 6;
    localparam int EDI_IDX = 7;

    logic [`AGEN_SEG_W-1:0] src_seg;

    // segment base shifted up and added to the offset
    function automatic logic [`AGEN_GPR_W-1:0] linear_addr(
        input logic [`AGEN_SEG_W-1:0] seg,
        input logic [`AGEN_GPR_W-1:0] offset
    );
        logic [`AGEN_GPR_W-1:0] base;
        base = '0;
        base[`AGEN_SEG_W-1:0] = seg;
        return (base << `AGEN_SEG_SHIFT) + offset;
    endfunction

    always_comb begin
        for (int i = 0; i < `AGEN_NUM_REGS; i++) begin
            bank[i] = '0;
            case (size)
                // AL..BL in 0-3, AH..BH in 4-7
                SZ_8: begin
                    bank[i][7:0] = state.gpr[i % 4][8*(i/4) +: 8];
                end
                SZ_16: begin
                    bank[i][15:0] = state.gpr[i][15:0];
                end
                SZ_32: begin
                    bank[i][`AGEN_GPR_W-1:0] = state.gpr[i];
                end
                SZ_MMX: begin
                    bank[i] = state.mmx[i];
                end
                default: begin
                    bank[i] = '0;
                end
            endcase
        end
    end

    // op1 source segment, DS unless overridden
    always_comb begin
        if (seg_override_valid) begin
            src_seg = seg_read(state.seg, seg_override);
        end else begin
            src_seg = state.seg[DS];
        end
    end

    // op0 is always ES:EDI
    assign string_addr[0] = linear_addr(state.seg[ES], state.gpr[EDI_IDX]);
    assign string_addr[1] = linear_addr(src_seg, state.gpr[ESI_IDX]);

    // no register view without an operand size
    always_comb begin
        if (size == SZ_NONE) begin
            assert final (bank == '0)
                else $error("register view not zero for SZ_NONE");
        end
    end

endmodule

/* hdl/agen_pkg.sv */
/*
 * Types shared by the address generation RTL and its testbench.
 * Import with agen_pkg::* in the module header.
 */

`include "agen_config.svh"

package agen_pkg;

    localparam int AGEN_NUM_SEGS = 6;
    localparam int AGEN_REG_IDX_W = $clog2(`AGEN_NUM_REGS);

    typedef enum logic [2:0] {
        NONE = 3'd0, REGISTER = 3'd1, SEGMENT = 3'd2, MMX = 3'd3,
        MODRM = 3'd4, IMMEDIATE = 3'd5, MEMORY = 3'd6, SYSTEM = 3'd7
    } opnd_kind_e;

    // codes 4, 6 and 7 are unused and give a zero register view
    typedef enum logic [2:0] {
        SZ_NONE = 3'd0, SZ_8 = 3'd1, SZ_16 = 3'd2, SZ_32 = 3'd3, SZ_MMX = 3'd5
    } opnd_size_e;

    typedef enum logic [2:0] {
        ES = 3'd0, CS = 3'd1, SS = 3'd2, DS = 3'd3, FS = 3'd4, GS = 3'd5
    } seg_idx_e;

    // bit 1 marks a pop
    typedef enum logic [1:0] {
        ST_NONE = 2'd0, ST_PUSH = 2'd1, ST_POP = 2'd2, ST_POP2 = 2'd3
    } stack_op_e;

    typedef logic [`AGEN_NUM_REGS-1:0][`AGEN_OPND_W-1:0] opnd_bank_t;
    typedef logic [`AGEN_NUM_REGS-1:0][`AGEN_GPR_W-1:0] gpr_bank_t;
    typedef logic [AGEN_NUM_SEGS-1:0][`AGEN_SEG_W-1:0] seg_bank_t;

    typedef struct packed {
        gpr_bank_t gpr;
        seg_bank_t seg;
        opnd_bank_t mmx;
    } arch_state_t;

    typedef struct packed {
        opnd_size_e size;
        opnd_kind_e op0_kind;
        opnd_kind_e op1_kind;
        logic [AGEN_REG_IDX_W-1:0] op0_reg;
        logic [AGEN_REG_IDX_W-1:0] op1_reg;
        logic [`AGEN_IMM_W-1:0] imm;
        stack_op_e stack_op;
        logic [`AGEN_GPR_W-1:0] stack_address;
        seg_idx_e seg_override;
        logic seg_override_valid;
    } agen_req_t;

    typedef struct packed {
        opnd_kind_e kind;
        logic [AGEN_REG_IDX_W-1:0] reg_idx;
        logic [`AGEN_IMM_W-1:0] imm;
        logic [`AGEN_GPR_W-1:0] str_addr;
    } opnd_req_t;

    typedef struct packed {
        opnd_size_e size;
        logic [`AGEN_OPND_W-1:0] op0;
        logic [`AGEN_OPND_W-1:0] op1;
        logic [AGEN_REG_IDX_W-1:0] op0_reg;
        logic [AGEN_REG_IDX_W-1:0] op1_reg;
        logic op0_is_reg;
        logic op0_is_segment;
        logic op0_is_mmx;
        logic op1_is_address;
        stack_op_e stack_op;
        logic [`AGEN_GPR_W-1:0] stack_address;
    } agen_resp_t;

    // segment lookup, indices past GS read as zero
    function automatic logic [`AGEN_SEG_W-1:0] seg_read(seg_bank_t segs, seg_idx_e idx);
        logic [`AGEN_SEG_W-1:0] val;
        val = '0;
        if (int'(idx) < AGEN_NUM_SEGS) begin
            val = segs[idx];
        end
        return val;
    endfunction

endpackage

/* hdl/agen_config.svh */
/*
 * Widths and counts for the address generation stage.
 * Include this wherever a register, immediate or operand width is needed.
 */

`ifndef AGEN_CONFIG_SVH
`define AGEN_CONFIG_SVH

// general purpose register width
`define AGEN_GPR_W 32

// segment register width
`define AGEN_SEG_W 16

// operand value width, also the MMX register width
`define AGEN_OPND_W 64

// immediate field width
`define AGEN_IMM_W 48

// registers per bank (GPR and MMX)
`define AGEN_NUM_REGS 8

// operand slots produced per micro-op
`define AGEN_NUM_OPND 2

// real mode style segment base shift
`define AGEN_SEG_SHIFT 4

`endif
